//--- compile.f
rtl/alu_op_pkg.sv
rtl/simd_pkg.sv
rtl/simd_adder.sv
rtl/simd_shifter.sv
rtl/simd_comparator.sv
rtl/alu_result_stage.sv
rtl/simd_alu.sv
test/simd_alu_tb.sv

//--- test/simd_alu_tb.sv
/*
  testbench for the registered SIMD ALU
  random requests with a fixed seed, all kept operators, all vector modes incl. reserved 01
  expected values come from a lane-by-lane reference model, checked in request order
  stops at the first mismatch, the run is bounded by a cycle counter
*/
`timescale 1ns/1ps
`default_nettype none

module simd_alu_tb;

  import simd_pkg::*;
  import alu_op_pkg::*;

  localparam int unsigned NUM_REQS       = 3000;
  localparam int unsigned TIMEOUT_CYCLES = 2 * NUM_REQS + 100;
  localparam int unsigned NUM_OPS        = 28;

  // one queued expectation, request kept for the error line
  typedef struct packed {
    alu_req_t          req;
    logic              cmp_bit;
    logic [DATA_W-1:0] result;
  } expect_t;

  logic              clk_i = 1'b0;
  logic              rst_n_i;
  logic              enable_i;
  alu_req_t          req_i;
  logic [DATA_W-1:0] result_o;
  logic              comparison_result_o;
  logic              valid_o;

  integer            seed = 92763;
  expect_t           exp_q[$];
  int unsigned       checked_cnt = 0;
  int unsigned       cycle_cnt = 0;
  logic              en_q;
  logic [DATA_W-1:0] last_result;
  logic              last_cmp;

  alu_opcode_e op_list [NUM_OPS] = '{
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROR, ALU_AND, ALU_OR, ALU_XOR,
    ALU_EQ, ALU_NE, ALU_GTS, ALU_GTU, ALU_GES, ALU_GEU, ALU_LTS, ALU_LTU, ALU_LES,
    ALU_LEU, ALU_SLTS, ALU_SLTU, ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU,
    ALU_RELU, ALU_RELU2, ALU_RELU4
  };

  simd_alu DUT (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .enable_i            (enable_i),
    .req_i               (req_i),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o),
    .valid_o             (valid_o)
  );

  // 4 ns period
  always #2 clk_i = ~clk_i;

  task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // returns {top-lane compare bit, result}
  function automatic logic [DATA_W:0] expected_result(input alu_req_t req);
    int unsigned       w;
    int unsigned       amt;
    logic [DATA_W-1:0] mask;
    logic [DATA_W-1:0] sflip;
    logic [DATA_W-1:0] la;
    logic [DATA_W-1:0] lb;
    logic [DATA_W-1:0] lane_res;
    logic [DATA_W-1:0] res;
    logic              is_signed;
    logic              gt;
    logic              eq;
    logic              rel;
    w = (req.vec_mode == VEC_MODE16) ? 16 : (req.vec_mode == VEC_MODE8) ? 8 : 32;
    mask = (w == 32) ? '1 : ((32'd1 << w) - 1);
    is_signed = req.operator inside {ALU_GTS, ALU_GES, ALU_LTS, ALU_LES, ALU_SLTS,
                                     ALU_MIN, ALU_MAX};
    // flipping the sign bit turns a signed compare into an unsigned one
    sflip = is_signed ? (32'd1 << (w - 1)) : '0;
    res = '0;
    rel = 1'b0;
    for (int unsigned l = 0; l < DATA_W / w; l++) begin
      la  = (req.operand_a >> (l * w)) & mask;
      lb  = (req.operand_b >> (l * w)) & mask;
      gt  = (la ^ sflip) > (lb ^ sflip);
      eq  = (la == lb);
      amt = lb & (w - 1);
      case (req.operator)
        ALU_NE:                               rel = !eq;
        ALU_GTS, ALU_GTU:                     rel = gt;
        ALU_GES, ALU_GEU:                     rel = gt | eq;
        ALU_LTS, ALU_LTU, ALU_SLTS, ALU_SLTU: rel = !(gt | eq);
        ALU_LES, ALU_LEU:                     rel = !gt;
        default:                              rel = eq;
      endcase
      case (req.operator)
        ALU_ADD: lane_res = (la + lb) & mask;
        ALU_SUB: lane_res = (la - lb) & mask;
        ALU_SLL: lane_res = (la << amt) & mask;
        ALU_SRL: lane_res = la >> amt;
        ALU_SRA: lane_res = (la >> amt) | (la[w-1] ? (mask & ~(mask >> amt)) : '0);
        // rotate only for the full word
        ALU_ROR: lane_res = (w == 32) ? ((la >> amt) | (la << (32 - amt))) : (la >> amt);
        ALU_EQ, ALU_NE, ALU_GTS, ALU_GTU, ALU_GES, ALU_GEU,
        ALU_LTS, ALU_LTU, ALU_LES, ALU_LEU: lane_res = rel ? mask : '0;
        ALU_MIN, ALU_MINU: lane_res = gt ? lb : la;
        ALU_MAX, ALU_MAXU: lane_res = gt ? la : lb;
        default: lane_res = '0;
      endcase
      res = res | (lane_res << (l * w));
    end
    // word-wide operators, rel now holds the top lane
    case (req.operator)
      ALU_AND:            res = req.operand_a & req.operand_b;
      ALU_OR:             res = req.operand_a | req.operand_b;
      ALU_XOR:            res = req.operand_a ^ req.operand_b;
      ALU_SLTS, ALU_SLTU: res = {{(DATA_W-1){1'b0}}, rel};
      ALU_RELU:           res = req.operand_a[31] ? '0 : req.operand_a;
      ALU_RELU2: begin
        res = req.operand_a;
        for (int h = 0; h < 2; h++) begin
          if (req.operand_a[16*h+15]) res[16*h +: 16] = '0;
        end
      end
      ALU_RELU4: begin
        res = req.operand_a;
        for (int i = 0; i < NUM_LANES; i++) begin
          if (req.operand_a[8*i+7]) res[8*i +: 8] = '0;
        end
      end
      default: ;
    endcase
    return {rel, res};
  endfunction

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic build_request(output alu_req_t req);
    int unsigned pick;
    req.operator  = op_list[$unsigned($random(seed)) % NUM_OPS];
    req.vec_mode  = vec_mode_e'(2'($random(seed)));
    req.operand_a = $random(seed);
    req.operand_b = $random(seed);
    pick = $unsigned($random(seed)) % 8;
    // equal and nearly equal operands for the compare paths
    if (pick == 0) req.operand_b = req.operand_a;
    if (pick == 1) req.operand_b = req.operand_a ^ (32'd1 << ($unsigned($random(seed)) % 32));
  endtask

  initial begin
    alu_req_t req;
    expect_t  item;
    int unsigned sent;
    rst_n_i  = 1'b0;
    enable_i = 1'b0;
    req_i    = '0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    sent = 0;
    while (sent < NUM_REQS) begin
      @(posedge clk_i);
      // strobe on about three cycles in four
      if (($random(seed) & 3) != 0) begin
        build_request(req);
        item.req = req;
        {item.cmp_bit, item.result} = expected_result(req);
        exp_q.push_back(item);
        req_i    <= req;
        enable_i <= 1'b1;
        sent++;
      end else begin
        enable_i <= 1'b0;
      end
    end
    @(posedge clk_i);
    enable_i <= 1'b0;
    wait (checked_cnt == NUM_REQS);
    // a stray valid_o after the last result is still caught here
    repeat (2) @(posedge clk_i);
    $display("Simulation passed");
    $finish;
  end

  //////////////////////////////////////////////////
  // checker, reads values registered on the previous edge
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    expect_t cur;
    if (!rst_n_i) begin
      en_q        = 1'b0;
      last_result = '0;
      last_cmp    = 1'b0;
      // the first edge only starts the reset of the output register
      if (cycle_cnt != 0) begin
        assert (!valid_o && result_o == '0 && !comparison_result_o) else begin
          $display("outputs are not cleared while reset is held");
          stop_on_failure();
        end
      end
    end else begin
      assert (valid_o == en_q) else begin
        $display("CHECK FAILED valid_o: expected 0x%h, actual 0x%h", en_q, valid_o);
        stop_on_failure();
      end
      if (valid_o) begin
        assert (exp_q.size() != 0) else begin
          $display("valid_o is high but no request is waiting for a result");
          stop_on_failure();
        end
        cur = exp_q.pop_front();
        assert (result_o == cur.result) else begin
          $display("CHECK FAILED result_o: expected 0x%08h, actual 0x%08h (op %s mode %b)",
                   cur.result, result_o, cur.req.operator.name(), cur.req.vec_mode);
          $display("  operand_a 0x%08h operand_b 0x%08h", cur.req.operand_a, cur.req.operand_b);
          stop_on_failure();
        end
        assert (comparison_result_o == cur.cmp_bit) else begin
          $display("CHECK FAILED comparison_result_o: expected 0x%h, actual 0x%h (op %s)",
                   cur.cmp_bit, comparison_result_o, cur.req.operator.name());
          stop_on_failure();
        end
        last_result = cur.result;
        last_cmp    = cur.cmp_bit;
        checked_cnt++;
      end else begin
        // zero before the first strobe, held afterwards
        assert (result_o == last_result) else begin
          $display("CHECK FAILED result_o: expected 0x%08h, actual 0x%08h (no strobe)",
                   last_result, result_o);
          stop_on_failure();
        end
        assert (comparison_result_o == last_cmp) else begin
          $display("CHECK FAILED comparison_result_o: expected 0x%h, actual 0x%h (no strobe)",
                   last_cmp, comparison_result_o);
          stop_on_failure();
        end
      end
      en_q = enable_i;
    end
  end

  // run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d of %0d results checked",
               cycle_cnt, checked_cnt, NUM_REQS);
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire

//--- rtl/simd_alu.sv
/*
  registered SIMD integer ALU, one execute stage
  req_i is sampled on a rising edge with enable_i high, the result follows
  one cycle later with valid_o, there is no back-pressure
  comparison_result_o is the compare outcome of the top lane
*/
`timescale 1ns/1ps
`default_nettype none

module simd_alu (
  input  wire                         clk_i,
  input  wire                         rst_n_i,
  input  wire                         enable_i,
  input  wire simd_pkg::alu_req_t     req_i,
  output logic [simd_pkg::DATA_W-1:0] result_o,
  output logic                        comparison_result_o,
  output logic                        valid_o
);

  import simd_pkg::*;

  logic [DATA_W-1:0] adder_result;
  logic [DATA_W-1:0] shift_result;
  cmp_flags_t        cmp_flags;

  // lane-partitioned add and sub
  simd_adder u_adder (
    .req_i (req_i),
    .sum_o (adder_result)
  );

  // shifts, also carries the sum on to the result stage
  simd_shifter u_shifter (
    .req_i          (req_i),
    .sum_i          (adder_result),
    .shift_result_o (shift_result)
  );

  // equal and greater terms for compares and min/max
  simd_comparator u_comparator (
    .req_i   (req_i),
    .flags_o (cmp_flags)
  );

  // logic ops, min/max, relu and the output register
  alu_result_stage u_result_stage (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .enable_i            (enable_i),
    .req_i               (req_i),
    .shift_result_i      (shift_result),
    .flags_i             (cmp_flags),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o),
    .valid_o             (valid_o)
  );

endmodule

`default_nettype wire

//--- rtl/alu_result_stage.sv
/*
  result select and output register of the execute stage
  a request sampled with enable_i shows up one cycle later with valid_o
  result_o and comparison_result_o hold their value while enable_i is low
  unknown operator codes give a zero result
*/
`timescale 1ns/1ps
`default_nettype none

module alu_result_stage (
  input  wire                         clk_i,
  input  wire                         rst_n_i,
  input  wire                         enable_i,
  input  wire simd_pkg::alu_req_t     req_i,
  input  wire [simd_pkg::DATA_W-1:0]  shift_result_i,
  input  wire simd_pkg::cmp_flags_t   flags_i,
  output logic [simd_pkg::DATA_W-1:0] result_o,
  output logic                        comparison_result_o,
  output logic                        valid_o
);

  import simd_pkg::*;
  import alu_op_pkg::*;

  logic [DATA_W-1:0]    op_a;
  logic [DATA_W-1:0]    op_b;
  logic                 cmp_top;
  logic [NUM_LANES-1:0] sel_a;
  logic [DATA_W-1:0]    minmax_result;
  logic [DATA_W-1:0]    cmp_vec_result;
  logic [DATA_W-1:0]    relu_result;
  logic [DATA_W-1:0]    result_d;

  assign op_a    = req_i.operand_a;
  assign op_b    = req_i.operand_b;
  assign cmp_top = flags_i.cmp_result[NUM_LANES-1];

  // max keeps a where a is greater, min the other way round
  assign sel_a = flags_i.is_greater ^ {NUM_LANES{op_is_min(req_i.operator)}};

  // min/max pick and lane-filled compare bits, byte by byte
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      minmax_result[LANE_W*i +: LANE_W]  = sel_a[i] ? op_a[LANE_W*i +: LANE_W] :
                                                      op_b[LANE_W*i +: LANE_W];
      cmp_vec_result[LANE_W*i +: LANE_W] = {LANE_W{flags_i.cmp_result[i]}};
    end
  end

  // relu zeroes each word, half or byte with its sign bit set
  always_comb begin
    relu_result = op_a;
    case (req_i.operator)
      ALU_RELU: begin
        if (op_a[DATA_W-1]) relu_result = '0;
      end
      ALU_RELU2: begin
        for (int h = 0; h < 2; h++) begin
          if (op_a[16*h+15]) relu_result[16*h +: 16] = '0;
        end
      end
      ALU_RELU4: begin
        for (int i = 0; i < NUM_LANES; i++) begin
          if (op_a[LANE_W*i+LANE_W-1]) relu_result[LANE_W*i +: LANE_W] = '0;
        end
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // result mux
  //////////////////////////////////////////////////

  always_comb begin
    case (req_i.operator)
      ALU_AND: result_d = op_a & op_b;
      ALU_OR:  result_d = op_a | op_b;
      ALU_XOR: result_d = op_a ^ op_b;
      // add and sub arrive through the shifter
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROR: result_d = shift_result_i;
      ALU_EQ, ALU_NE, ALU_GTS, ALU_GTU, ALU_GES, ALU_GEU,
      ALU_LTS, ALU_LTU, ALU_LES, ALU_LEU: result_d = cmp_vec_result;
      ALU_SLTS, ALU_SLTU: result_d = {{(DATA_W-1){1'b0}}, cmp_top};
      ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU: result_d = minmax_result;
      ALU_RELU, ALU_RELU2, ALU_RELU4: result_d = relu_result;
      default: result_d = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o             <= 1'b0;
      result_o            <= '0;
      comparison_result_o <= 1'b0;
    end else begin
      valid_o <= enable_i;
      // hold last result between strobes
      if (enable_i) begin
        result_o            <= result_d;
        comparison_result_o <= cmp_top;
      end
    end
  end

  // min/max picks whole lanes, so the greater flags agree inside a 16- or 32-bit lane
  a_greater_merged: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    enable_i && (req_i.vec_mode != VEC_MODE8) |->
      (flags_i.is_greater[3] == flags_i.is_greater[2]) &&
      (flags_i.is_greater[1] == flags_i.is_greater[0])
  ) else $error("is_greater is not merged to the lane width");

  // a strobed request carries a defined operator
  a_operator_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) enable_i |-> !$isunknown(req_i.operator)
  ) else $error("operator is X or Z on a strobed request");

endmodule

`default_nettype wire

//--- rtl/simd_comparator.sv
/*
  lane comparator for the vector compares, SLT and min/max
  greater and equal are formed per byte and chained up to the lane width
  signed relations look at the sign bit of the top byte of each lane only
  unused relation codes report the equal term
*/
`timescale 1ns/1ps
`default_nettype none

module simd_comparator (
  input  wire simd_pkg::alu_req_t     req_i,
  output simd_pkg::cmp_flags_t        flags_o
);

  import simd_pkg::*;
  import alu_op_pkg::*;

  logic [DATA_W-1:0]    op_a;
  logic [DATA_W-1:0]    op_b;
  logic [NUM_LANES-1:0] cmp_signed;
  logic [NUM_LANES-1:0] eq_byte;
  logic [NUM_LANES-1:0] gt_byte;
  logic [NUM_LANES-1:0] is_equal;
  logic [NUM_LANES-1:0] is_greater;
  logic [NUM_LANES-1:0] cmp_result;

  assign op_a = req_i.operand_a;
  assign op_b = req_i.operand_b;

  // bytes that hold a lane sign
  always_comb begin
    cmp_signed = '0;
    if (op_is_signed_cmp(req_i.operator)) begin
      case (req_i.vec_mode)
        VEC_MODE16: cmp_signed = 4'b1010;
        VEC_MODE8:  cmp_signed = 4'b1111;
        default:    cmp_signed = 4'b1000;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // byte terms
  //////////////////////////////////////////////////

  // a ninth bit carries the sign where it counts, zero elsewhere
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      eq_byte[i] = (op_a[LANE_W*i +: LANE_W] == op_b[LANE_W*i +: LANE_W]);
      gt_byte[i] = $signed({op_a[LANE_W*i+LANE_W-1] & cmp_signed[i], op_a[LANE_W*i +: LANE_W]}) >
                   $signed({op_b[LANE_W*i+LANE_W-1] & cmp_signed[i], op_b[LANE_W*i +: LANE_W]});
    end
  end

  // chain upper byte over lower byte, copy the lane result into each byte
  always_comb begin
    case (req_i.vec_mode)
      VEC_MODE16: begin
        is_equal   = {{2{eq_byte[3] & eq_byte[2]}}, {2{eq_byte[1] & eq_byte[0]}}};
        is_greater = {{2{gt_byte[3] | (eq_byte[3] & gt_byte[2])}},
                      {2{gt_byte[1] | (eq_byte[1] & gt_byte[0])}}};
      end
      VEC_MODE8: begin
        is_equal   = eq_byte;
        is_greater = gt_byte;
      end
      default: begin
        is_equal   = {NUM_LANES{&eq_byte}};
        is_greater = {NUM_LANES{gt_byte[3] | (eq_byte[3] & (gt_byte[2] |
                                (eq_byte[2] & (gt_byte[1] | (eq_byte[1] & gt_byte[0])))))}};
      end
    endcase
  end

  //////////////////////////////////////////////////
  // relation
  //////////////////////////////////////////////////

  always_comb begin
    case (req_i.operator)
      ALU_NE:                               cmp_result = ~is_equal;
      ALU_GTS, ALU_GTU:                     cmp_result = is_greater;
      ALU_GES, ALU_GEU:                     cmp_result = is_greater | is_equal;
      ALU_LTS, ALU_LTU, ALU_SLTS, ALU_SLTU: cmp_result = ~(is_greater | is_equal);
      ALU_LES, ALU_LEU:                     cmp_result = ~is_greater;
      default:                              cmp_result = is_equal;
    endcase
  end

  assign flags_o = '{is_greater: is_greater, cmp_result: cmp_result};

endmodule

`default_nettype wire

//--- rtl/simd_shifter.sv
/*
  per-lane shifter, only right shifts are built
  SLL reverses the operand and the lane amounts, shifts right and reverses back
  amounts: 5 bits per word, 4 per half, 3 per byte, upper bits of each lane ignored
  ROR rotates only in 32-bit mode, vector modes shift logically
  ADD and SUB pass the adder sum through unshifted
*/
`timescale 1ns/1ps
`default_nettype none

module simd_shifter (
  input  wire simd_pkg::alu_req_t     req_i,
  input  wire [simd_pkg::DATA_W-1:0]  sum_i,
  output logic [simd_pkg::DATA_W-1:0] shift_result_o
);

  import simd_pkg::*;
  import alu_op_pkg::*;

  logic                pass_sum;
  logic                shift_left;
  logic                shift_arith;
  logic [DATA_W-1:0]   a_rev;
  logic [DATA_W-1:0]   amt_left;
  logic [DATA_W-1:0]   amt;
  logic [DATA_W-1:0]   shift_in;
  logic [2*DATA_W-1:0] word_in;
  logic [DATA_W-1:0]   right_result;
  logic [DATA_W-1:0]   right_rev;

  assign pass_sum    = op_is_addsub(req_i.operator);
  assign shift_left  = (req_i.operator == ALU_SLL);
  assign shift_arith = (req_i.operator == ALU_SRA);

  assign a_rev = {<<{req_i.operand_a}};

  // reversed operand means reversed lane order of the amounts
  always_comb begin
    case (req_i.vec_mode)
      VEC_MODE16: amt_left = {<<16{req_i.operand_b}};
      VEC_MODE8:  amt_left = {<<8{req_i.operand_b}};
      default:    amt_left = req_i.operand_b;
    endcase
  end

  // sum goes through with amount zero
  assign shift_in = pass_sum ? sum_i : (shift_left ? a_rev : req_i.operand_a);
  assign amt      = pass_sum ? '0 : (shift_left ? amt_left : req_i.operand_b);

  //////////////////////////////////////////////////
  // right shift per lane
  //////////////////////////////////////////////////

  // 64-bit image, upper half is the word again for ROR or the sign fill
  assign word_in = (req_i.operator == ALU_ROR) ? {shift_in, shift_in} :
                   {{DATA_W{shift_arith & shift_in[DATA_W-1]}}, shift_in};

  always_comb begin
    case (req_i.vec_mode)
      VEC_MODE16: begin
        for (int h = 0; h < 2; h++) begin
          right_result[16*h +: 16] = 16'($signed({shift_arith & shift_in[16*h+15],
                                                  shift_in[16*h +: 16]}) >>> amt[16*h +: 4]);
        end
      end
      VEC_MODE8: begin
        for (int i = 0; i < NUM_LANES; i++) begin
          right_result[LANE_W*i +: LANE_W] =
            LANE_W'($signed({shift_arith & shift_in[LANE_W*i+LANE_W-1],
                             shift_in[LANE_W*i +: LANE_W]}) >>> amt[LANE_W*i +: 3]);
        end
      end
      default: begin
        right_result = DATA_W'(word_in >> amt[4:0]);
      end
    endcase
  end

  // undo the reversal for left shifts
  assign right_rev      = {<<{right_result}};
  assign shift_result_o = shift_left ? right_rev : right_result;

endmodule

`default_nettype wire

//--- rtl/simd_adder.sv
/*
  partitioned adder for ADD and SUB in 32-bit, 2x16 and 4x8 mode
  a separator bit below each byte either passes, blocks or injects a carry
  results wrap inside each lane, no carry out or overflow is reported
*/
`timescale 1ns/1ps
`default_nettype none

module simd_adder (
  input  wire simd_pkg::alu_req_t     req_i,
  output logic [simd_pkg::DATA_W-1:0] sum_o
);

  import simd_pkg::*;
  import alu_op_pkg::*;

  logic                        negate_b;
  logic [DATA_W-1:0]           op_b;
  logic [NUM_LANES-1:0]        lane_start;
  logic [DATA_W+NUM_LANES-1:0] in_a;
  logic [DATA_W+NUM_LANES-1:0] in_b;
  logic [DATA_W+NUM_LANES-1:0] sum_exp;

  // a - b as a + ~b + 1, the +1 comes in per lane
  assign negate_b = (req_i.operator == ALU_SUB);
  assign op_b     = negate_b ? ~req_i.operand_b : req_i.operand_b;

  // bytes that open a new lane
  always_comb begin
    case (req_i.vec_mode)
      VEC_MODE16: lane_start = 4'b0101;
      VEC_MODE8:  lane_start = 4'b1111;
      default:    lane_start = 4'b0001;
    endcase
  end

  // separator below byte i
  //   inside a lane      a=1 b=0, carry ripples on
  //   lane start, add    a=0 b=0, carry is swallowed
  //   lane start, sub    a=1 b=1, fresh carry-in of one
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      in_a[(LANE_W+1)*i]             = ~lane_start[i] | negate_b;
      in_b[(LANE_W+1)*i]             = lane_start[i] & negate_b;
      in_a[(LANE_W+1)*i+1 +: LANE_W] = req_i.operand_a[LANE_W*i +: LANE_W];
      in_b[(LANE_W+1)*i+1 +: LANE_W] = op_b[LANE_W*i +: LANE_W];
    end
  end

  // one 36-bit add, the carry out of the top byte is lost
  assign sum_exp = in_a + in_b;

  // drop the separators again
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      sum_o[LANE_W*i +: LANE_W] = sum_exp[(LANE_W+1)*i+1 +: LANE_W];
    end
  end

endmodule

`default_nettype wire

//--- rtl/simd_pkg.sv
/*
  data layout of the SIMD ALU
  a word is one 32-bit lane, two 16-bit lanes or four 8-bit lanes
  vector mode 01 is reserved and behaves as 32-bit everywhere
*/
`default_nettype none

package simd_pkg;

  localparam int unsigned DATA_W    = 32;
  localparam int unsigned LANE_W    = 8;
  localparam int unsigned NUM_LANES = DATA_W / LANE_W;

  // lane split of the operands
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  // one ALU request, 73 bits
  typedef struct packed {
    alu_op_pkg::alu_opcode_e operator;
    vec_mode_e               vec_mode;
    logic [DATA_W-1:0]       operand_a;
    logic [DATA_W-1:0]       operand_b;
  } alu_req_t;

  // comparator outputs, one bit per byte, already merged to the lane width
  typedef struct packed {
    logic [NUM_LANES-1:0] is_greater;
    logic [NUM_LANES-1:0] cmp_result;
  } cmp_flags_t;

endpackage

`default_nettype wire

//--- rtl/alu_op_pkg.sv
/*
  operator codes of the SIMD integer ALU
  codes follow the execute-stage encoding of the core, the RELU forms sit on free codes
  any code outside this enum gives a zero result
*/
`default_nettype none

package alu_op_pkg;

  typedef enum logic [6:0] {
    // arithmetic, through the partitioned adder
    ALU_ADD   = 7'b0011000,
    ALU_SUB   = 7'b0011001,
    // shifts and rotate
    ALU_SRA   = 7'b0100100,
    ALU_SRL   = 7'b0100101,
    ALU_ROR   = 7'b0100110,
    ALU_SLL   = 7'b0100111,
    // logic
    ALU_AND   = 7'b0010101,
    ALU_OR    = 7'b0101110,
    ALU_XOR   = 7'b0101111,
    // vector compares, one result per lane
    ALU_LTS   = 7'b0000000,
    ALU_LTU   = 7'b0000001,
    ALU_LES   = 7'b0000100,
    ALU_LEU   = 7'b0000101,
    ALU_GTS   = 7'b0001000,
    ALU_GTU   = 7'b0001001,
    ALU_GES   = 7'b0001010,
    ALU_GEU   = 7'b0001011,
    ALU_EQ    = 7'b0001100,
    ALU_NE    = 7'b0001101,
    // scalar set-less-than, top lane into bit 0
    ALU_SLTS  = 7'b0000010,
    ALU_SLTU  = 7'b0000011,
    // min and max per lane
    ALU_MIN   = 7'b0010000,
    ALU_MINU  = 7'b0010001,
    ALU_MAX   = 7'b0010010,
    ALU_MAXU  = 7'b0010011,
    // relu on word, halves, bytes
    ALU_RELU  = 7'b0111000,
    ALU_RELU2 = 7'b0111001,
    ALU_RELU4 = 7'b0111010
  } alu_opcode_e;

  // add and sub reach the result through the shifter with no shift
  function automatic logic op_is_addsub(input alu_opcode_e op);
    return (op == ALU_ADD) || (op == ALU_SUB);
  endfunction

  // relations that take the lane sign bit into account
  function automatic logic op_is_signed_cmp(input alu_opcode_e op);
    return op inside {ALU_GTS, ALU_GES, ALU_LTS, ALU_LES, ALU_SLTS, ALU_MIN, ALU_MAX};
  endfunction

  // min flips the greater select of the min/max mux
  function automatic logic op_is_min(input alu_opcode_e op);
    return (op == ALU_MIN) || (op == ALU_MINU);
  endfunction

endpackage

`default_nettype wire
